//--- run_sim.sh
#!/bin/sh
# build and run the sd_autotest testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module sd_autotest_tb \
  -f sd_autotest.f -o sd_autotest_sim > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sd_autotest_sim > sim.log 2>&1 ||
  { cat sim.log; echo "simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- sd_autotest.f
+incdir+verilog
verilog/at_pkg.sv
verilog/at_counters.sv
verilog/at_record_buf.sv
verilog/at_result_check.sv
verilog/at_fsm.sv
verilog/sd_autotest.sv
sim/sd_autotest_assertions.sv
sim/sd_autotest_tb.sv

//--- sim/sd_autotest_assertions.sv
`timescale 1ns/1ps

module sd_autotest_assertions (
  input logic             clk,
  input logic             rst,
  input at_pkg::sd_req_t  sd_req_i,
  input at_pkg::uut_req_t uut_req_i,
  input logic [31:0]      err_count_i
);

  // a block transfer is a read or a write, never both
  rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(sd_req_i.r_block && sd_req_i.w_block))
    else $error("r_block and w_block are high together");

  rd_byte_in_block: assert property (@(posedge clk) disable iff (rst)
    sd_req_i.r_byte |-> sd_req_i.r_block)
    else $error("r_byte is high outside a block read");

  wr_byte_in_block: assert property (@(posedge clk) disable iff (rst)
    sd_req_i.w_byte |-> sd_req_i.w_block)
    else $error("w_byte is high outside a block write");

  // unsigned difference, so a decrement fails too
  err_step: assert property (@(posedge clk) disable iff (rst)
    (err_count_i - $past(err_count_i)) <= 32'd1)
    else $error("error count moved by more than one");

  uut_held: assert property (@(posedge clk) disable iff (rst)
    (sd_req_i.rst || sd_req_i.r_block || sd_req_i.w_block) |-> uut_req_i.rst)
    else $error("uut out of reset during an sd transfer");

endmodule

bind sd_autotest sd_autotest_assertions u_assertions (
  .clk         (clk),
  .rst         (rst),
  .sd_req_i    (sd_req_o),
  .uut_req_i   (uut_req_o),
  .err_count_i (err_count_o)
);

//--- sim/sd_autotest_tb.sv
`timescale 1ns/1ps
`include "at_settings.svh"

module sd_autotest_tb;

  import at_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int NUM_RECORDS = 5;
  localparam int BLK         = `AT_BLOCK_BYTES;
  // one block read plus one block write at the slowest host pace
  localparam int WAIT_CYCLES = BLK * 2 * 12;
  localparam int WATCHDOG_NS = NUM_TESTS * WAIT_CYCLES * 10;

  logic        clk;
  logic        rst;
  logic        start_i;
  sd_rsp_t     sd_rsp;
  sd_req_t     sd_req;
  uut_rsp_t    uut_rsp;
  uut_req_t    uut_req;
  logic [31:0] err_count;
  logic        running;

  integer      seed = 75;
  int          errors;
  int          checks;
  int          tests_run;
  // 0 normal, 1 error flag, 2 never finishes
  int          uut_mode;
  int          blocks_written;
  logic [7:0]  rd_mem [longint];
  logic [7:0]  wr_mem [longint];
  logic [31:0] rd_addrs [$];
  logic [31:0] wr_addrs [$];
  logic [31:0] rec_in1 [NUM_RECORDS];
  logic [31:0] rec_in2 [NUM_RECORDS];

  sd_autotest dut (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .sd_rsp_i    (sd_rsp),
    .sd_req_o    (sd_req),
    .uut_rsp_i   (uut_rsp),
    .uut_req_o   (uut_req),
    .err_count_o (err_count),
    .running_o   (running)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic longint mem_key(logic [31:0] addr, int pos);
    return longint'(addr) * BLK + pos;
  endfunction

  function automatic int busy_delay();
    return 1 + ($unsigned($random(seed)) % 4);
  endfunction

  function automatic logic [7:0] written_byte(logic [31:0] addr, int pos);
    if (wr_mem.exists(mem_key(addr, pos))) begin
      return wr_mem[mem_key(addr, pos)];
    end
    return 8'hxx;
  endfunction

  // result words go out lsb first
  function automatic logic [31:0] written_word(logic [31:0] addr, int pos);
    logic [31:0] word;
    for (int i = 0; i < 4; i++) begin
      word[8*i +: 8] = written_byte(addr, pos + i);
    end
    return word;
  endfunction

  function automatic void store_record(int blk, logic [31:0] sig, logic [31:0] in1,
                                       logic [31:0] in2, logic [31:0] expected);
    logic [31:0] addr;
    addr = `AT_FIRST_BLOCK + blk;
    // filler differs per block and per byte
    for (int pos = 16; pos < BLK; pos++) begin
      rd_mem[mem_key(addr, pos)] = 8'(pos * 7 + (pos >> 8) * 29 + blk * 53);
    end
    for (int i = 0; i < 4; i++) begin
      rd_mem[mem_key(addr, i)]      = sig[8*(3-i) +: 8];
      rd_mem[mem_key(addr, 4 + i)]  = in1[8*i +: 8];
      rd_mem[mem_key(addr, 8 + i)]  = in2[8*i +: 8];
      rd_mem[mem_key(addr, 12 + i)] = expected[8*i +: 8];
    end
    rec_in1[blk] = in1;
    rec_in2[blk] = in2;
  endfunction

  task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_req(string name, sd_req_t expected, sd_req_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_state(string name, at_state_e expected, at_state_e actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, expected.name(),
               actual.name());
    end
  endtask

  task automatic report_failure(string msg);
    errors++;
    $display("ERROR %s", msg);
  endtask

  task automatic finish_test(string name, int errors_before);
    tests_run++;
    $display("test %s %s", name, (errors == errors_before) ? "passed" : "failed");
  endtask

  // write data is taken as busy rises after a random delay
  task automatic host_handshake(input logic [7:0] rd_data, output logic [7:0] wr_data);
    repeat (busy_delay()) @(negedge clk);
    wr_data     = sd_req.data_in;
    sd_rsp.busy = 1'b1;
    repeat (busy_delay()) @(negedge clk);
    sd_rsp.data_out = rd_data;
    sd_rsp.busy     = 1'b0;
  endtask

  initial begin : sd_host
    logic [31:0] addr;
    logic [7:0]  rd_data;
    logic [7:0]  wr_data;
    int          pos;
    sd_rsp = '0;
    forever begin
      @(negedge clk);
      if (sd_req.rst) begin
        host_handshake(8'h00, wr_data);
      end else if (sd_req.r_block) begin
        addr = sd_req.block_addr;
        rd_addrs.push_back(addr);
        host_handshake(8'h00, wr_data);
        pos = 0;
        while (sd_req.r_block) begin
          @(negedge clk);
          if (sd_req.r_byte) begin
            rd_data = rd_mem.exists(mem_key(addr, pos)) ? rd_mem[mem_key(addr, pos)] : 8'h00;
            host_handshake(rd_data, wr_data);
            pos++;
          end
        end
      end else if (sd_req.w_block) begin
        addr = sd_req.block_addr;
        wr_addrs.push_back(addr);
        host_handshake(8'h00, wr_data);
        pos = 0;
        while (sd_req.w_block) begin
          @(negedge clk);
          if (sd_req.w_byte) begin
            host_handshake(8'h00, wr_data);
            wr_mem[mem_key(addr, pos)] = wr_data;
            pos++;
          end
        end
        blocks_written++;
      end
    end
  end

  // uut adds its operands five cycles after leaving reset
  initial begin : uut_model
    int cycles;
    uut_rsp = '0;
    cycles  = 0;
    forever begin
      @(negedge clk);
      if (uut_req.rst) begin
        cycles  = 0;
        uut_rsp = '0;
      end else begin
        cycles++;
        if (cycles == 5 && uut_mode != 2) begin
          uut_rsp.result = uut_req.in1 + uut_req.in2;
          uut_rsp.done   = (uut_mode == 0);
          uut_rsp.err    = (uut_mode == 1);
        end
      end
    end
  end

  task automatic wait_written(int count);
    int waited;
    waited = 0;
    while (blocks_written < count && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (blocks_written < count) begin
      report_failure($sformatf("result record %0d was not written back in time", count - 1));
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (running && waited < WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (running) begin
      report_failure("controller did not return to idle after the bad signature");
    end
  endtask

  task automatic check_written(string name, int blk, logic [31:0] exp_output,
                               logic [31:0] exp_errs);
    logic [31:0] addr;
    logic [7:0]  exp_byte;
    logic [7:0]  act_byte;
    int          bad_pos;
    addr     = `AT_FIRST_BLOCK + blk;
    bad_pos  = -1;
    exp_byte = 8'h00;
    act_byte = 8'h00;
    // record echo in front and padding after the two result words
    for (int pos = 0; pos < BLK; pos++) begin
      if (bad_pos < 0 && (pos < 16 || pos >= 24)) begin
        exp_byte = (pos < 16) ? rd_mem[mem_key(addr, pos)] : 8'hFF;
        act_byte = written_byte(addr, pos);
        if (act_byte !== exp_byte) begin
          bad_pos = pos;
        end
      end
    end
    check_word($sformatf("%s byte %0d", name, bad_pos), 32'(exp_byte), 32'(act_byte));
    check_word({name, " output"}, exp_output, written_word(addr, 16));
    check_word({name, " err count"}, exp_errs, err_count);
  endtask

  task automatic check_cycle_range(string name, int blk, logic [31:0] lo, logic [31:0] hi);
    logic [31:0] cycles;
    cycles = written_word(`AT_FIRST_BLOCK + blk, 20);
    checks++;
    if ($isunknown(cycles) || cycles < lo || cycles > hi) begin
      errors++;
      $display("CHECK FAILED %s cycle count: expected %0d to %0d, actual %0d", name, lo, hi,
               cycles);
    end
  endtask

  task automatic after_reset();
    sd_req_t flags;
    int      e0;
    e0 = errors;
    @(negedge clk);
    flags            = sd_req;
    flags.block_addr = '0;
    flags.data_in    = '0;
    check_req("after_reset sd_req flags", '0, flags);
    check_word("after_reset running", 32'd0, 32'(running));
    check_word("after_reset err count", 32'd0, err_count);
    check_word("after_reset uut rst", 32'd1, 32'(uut_req.rst));
    check_state("after_reset state", IDLE, dut.u_fsm.state_q);
    finish_test("after_reset", e0);
  endtask

  task automatic passing_record();
    logic [31:0] base;
    int          e0;
    e0       = errors;
    base     = err_count;
    uut_mode = 0;
    start_i  = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    check_word("passing_record running", 32'd1, 32'(running));
    wait_written(1);
    check_written("passing_record", 0, rec_in1[0] + rec_in2[0], base);
    check_cycle_range("passing_record", 0, 32'd1, `AT_TIMEOUT_CYCLES);
    finish_test("passing_record", e0);
  endtask

  task automatic wrong_expected();
    logic [31:0] base;
    int          e0;
    e0       = errors;
    base     = err_count;
    uut_mode = 0;
    wait_written(2);
    check_written("wrong_expected", 1, rec_in1[1] + rec_in2[1], base + 1);
    finish_test("wrong_expected", e0);
  endtask

  task automatic uut_error_flag();
    logic [31:0] base;
    int          e0;
    e0       = errors;
    base     = err_count;
    uut_mode = 1;
    wait_written(3);
    check_written("uut_error_flag", 2, rec_in1[2] + rec_in2[2], base + 1);
    finish_test("uut_error_flag", e0);
  endtask

  task automatic uut_timeout();
    logic [31:0] base;
    int          e0;
    e0       = errors;
    base     = err_count;
    uut_mode = 2;
    wait_written(4);
    // a hung uut leaves its result at zero
    check_written("uut_timeout", 3, 32'd0, base + 1);
    check_cycle_range("uut_timeout", 3, `AT_TIMEOUT_CYCLES + 1, 32'hFFFF_FFFF);
    finish_test("uut_timeout", e0);
  endtask

  task automatic bad_signature();
    int e0;
    e0       = errors;
    uut_mode = 0;
    wait_idle();
    check_word("bad_signature blocks read", NUM_RECORDS, rd_addrs.size());
    check_word("bad_signature blocks written", NUM_RECORDS - 1, wr_addrs.size());
    check_word("bad_signature first read", `AT_FIRST_BLOCK, rd_addrs[0]);
    for (int i = 1; i < rd_addrs.size(); i++) begin
      check_word($sformatf("bad_signature read %0d", i), rd_addrs[i-1] + 1, rd_addrs[i]);
    end
    check_state("bad_signature state", IDLE, dut.u_fsm.state_q);
    finish_test("bad_signature", e0);
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    rst            = 1'b1;
    start_i        = 1'b0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    uut_mode       = 0;
    blocks_written = 0;
    store_record(0, `AT_SIGNATURE, 32'h1234_5678, 32'h0101_0101, 32'h1335_5779);
    store_record(1, `AT_SIGNATURE, 32'hDEAD_0000, 32'h0000_BEEF, 32'h1111_1111);
    store_record(2, `AT_SIGNATURE, 32'h0000_0FFF, 32'h0000_0001, 32'h0000_1000);
    store_record(3, `AT_SIGNATURE, 32'h0000_0007, 32'h0000_0009, 32'h0000_0010);
    store_record(4, 32'hAABB_CCDE, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003);
    repeat (10) @(negedge clk);
    rst = 1'b0;
    after_reset();
    passing_record();
    wrong_expected();
    uut_error_flag();
    uut_timeout();
    bad_signature();
    $display("summary: %0d tests, %0d checks, %0d failed", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verilog/at_counters.sv
`timescale 1ns/1ps
`include "at_settings.svh"

module at_counters (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 byte_clr_i,
  input  logic                 byte_inc_i,
  input  logic                 blk_clr_i,
  input  logic                 blk_inc_i,
  input  logic                 tmr_clr_i,
  input  logic                 tmr_run_i,
  output at_pkg::at_byte_cnt_t byte_pos_o,
  output logic [31:0]          block_addr_o,
  output logic [31:0]          exec_cycles_o,
  output logic                 timeout_o
);

  // byte position within the current block transfer
  always_ff @(posedge clk) begin
    if (rst || byte_clr_i) begin
      byte_pos_o <= '0;
    end else if (byte_inc_i) begin
      byte_pos_o <= byte_pos_o + 1'b1;
    end
  end

  // clear loads the first record block
  always_ff @(posedge clk) begin
    if (rst) begin
      block_addr_o <= `AT_FIRST_BLOCK;
    end else if (blk_clr_i) begin
      block_addr_o <= `AT_FIRST_BLOCK;
    end else if (blk_inc_i) begin
      block_addr_o <= block_addr_o + 32'd1;
    end
  end

  // uut run length, held after the run for write-back
  always_ff @(posedge clk) begin
    if (rst || tmr_clr_i) begin
      exec_cycles_o <= '0;
    end else if (tmr_run_i) begin
      exec_cycles_o <= exec_cycles_o + 32'd1;
    end
  end

  assign timeout_o = (exec_cycles_o > 32'(`AT_TIMEOUT_CYCLES));

endmodule

//--- verilog/at_fsm.sv
`timescale 1ns/1ps
`include "at_settings.svh"

module at_fsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start_i,
  input  logic                 sd_busy_i,
  input  logic                 uut_done_i,
  input  logic                 uut_err_i,
  input  at_pkg::at_byte_cnt_t byte_pos_i,
  input  logic                 timeout_i,
  input  logic                 sig_ok_i,
  output logic                 sd_rst_o,
  output logic                 r_block_o,
  output logic                 r_byte_o,
  output logic                 w_block_o,
  output logic                 w_byte_o,
  output logic                 uut_rst_o,
  output logic                 running_o,
  output logic                 byte_clr_o,
  output logic                 byte_inc_o,
  output logic                 blk_clr_o,
  output logic                 blk_inc_o,
  output logic                 tmr_clr_o,
  output logic                 tmr_run_o,
  output logic                 load_en_o,
  output logic                 capture_o,
  output logic                 compare_en_o,
  output logic                 clear_rec_o
);

  import at_pkg::*;

  localparam at_byte_cnt_t block_end = at_byte_cnt_t'(`AT_BLOCK_BYTES);

  at_state_e state_q;
  at_state_e state_d;
  // busy seen high since entering the current state
  logic      acc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || state_q != state_d) begin
      acc_q <= 1'b0;
    end else if (sd_busy_i) begin
      acc_q <= 1'b1;
    end
  end

  always_comb begin
    state_d      = state_q;
    sd_rst_o     = 1'b0;
    r_block_o    = 1'b0;
    r_byte_o     = 1'b0;
    w_block_o    = 1'b0;
    w_byte_o     = 1'b0;
    uut_rst_o    = 1'b1;
    byte_clr_o   = 1'b0;
    byte_inc_o   = 1'b0;
    blk_clr_o    = 1'b0;
    blk_inc_o    = 1'b0;
    tmr_clr_o    = 1'b0;
    tmr_run_o    = 1'b0;
    load_en_o    = 1'b0;
    capture_o    = 1'b0;
    compare_en_o = 1'b0;
    clear_rec_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (start_i) begin
          blk_clr_o = 1'b1;
          state_d   = SD_RESET;
        end
      end
      SD_RESET: begin
        sd_rst_o = 1'b1;
        if (sd_busy_i) begin
          state_d = SD_RESET_WAIT;
        end
      end
      SD_RESET_WAIT: begin
        if (!sd_busy_i) begin
          state_d = RD_BLOCK;
        end
      end
      RD_BLOCK: begin
        r_block_o   = 1'b1;
        byte_clr_o  = 1'b1;
        clear_rec_o = 1'b1;
        if (acc_q && !sd_busy_i) begin
          state_d = RD_BYTE;
        end
      end
      RD_BYTE: begin
        if (byte_pos_i == block_end) begin
          state_d = CHECK_SIG;
        end else begin
          r_block_o = 1'b1;
          r_byte_o  = 1'b1;
          if (sd_busy_i) begin
            state_d = RD_WAIT;
          end
        end
      end
      RD_WAIT: begin
        r_block_o = 1'b1;
        if (!sd_busy_i) begin
          load_en_o  = 1'b1;
          byte_inc_o = 1'b1;
          state_d    = RD_BYTE;
        end
      end
      CHECK_SIG: begin
        // a record without signature ends the run
        state_d = sig_ok_i ? START : IDLE;
      end
      START: begin
        uut_rst_o = 1'b0;
        tmr_clr_o = 1'b1;
        state_d   = RUN;
      end
      RUN: begin
        uut_rst_o = 1'b0;
        tmr_run_o = 1'b1;
        // sample while the uut is still out of reset
        if (uut_done_i || uut_err_i || timeout_i) begin
          capture_o = 1'b1;
          state_d   = CAPTURE;
        end
      end
      CAPTURE: begin
        byte_clr_o = 1'b1;
        state_d    = COMPARE;
      end
      COMPARE: begin
        compare_en_o = 1'b1;
        state_d      = WR_BLOCK;
      end
      WR_BLOCK: begin
        w_block_o = 1'b1;
        if (acc_q && !sd_busy_i) begin
          state_d = WR_BYTE;
        end
      end
      WR_BYTE: begin
        if (byte_pos_i == block_end) begin
          state_d = NEXT_BLOCK;
        end else begin
          w_block_o = 1'b1;
          w_byte_o  = 1'b1;
          if (sd_busy_i) begin
            state_d = WR_WAIT;
          end
        end
      end
      WR_WAIT: begin
        w_block_o = 1'b1;
        if (!sd_busy_i) begin
          byte_inc_o = 1'b1;
          state_d    = WR_BYTE;
        end
      end
      NEXT_BLOCK: begin
        blk_inc_o = 1'b1;
        state_d   = RD_BLOCK;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign running_o = (state_q != IDLE);

endmodule

//--- verilog/at_pkg.sv
`include "at_settings.svh"

package at_pkg;

  typedef enum logic [3:0] {
    IDLE,
    SD_RESET,
    SD_RESET_WAIT,
    RD_BLOCK,
    RD_BYTE,
    RD_WAIT,
    CHECK_SIG,
    START,
    RUN,
    CAPTURE,
    COMPARE,
    WR_BLOCK,
    WR_BYTE,
    WR_WAIT,
    NEXT_BLOCK
  } at_state_e;

  // byte position inside a block, reaches AT_BLOCK_BYTES
  typedef logic [9:0] at_byte_cnt_t;

  typedef struct packed {
    logic        rst;
    logic        r_block;
    logic        r_byte;
    logic        w_block;
    logic        w_byte;
    logic [31:0] block_addr;
    logic [7:0]  data_in;
  } sd_req_t;

  typedef struct packed {
    logic       busy;
    logic [7:0] data_out;
  } sd_rsp_t;

  typedef struct packed {
    logic                 rst;
    logic [`AT_IN1_W-1:0] in1;
    logic [`AT_IN2_W-1:0] in2;
  } uut_req_t;

  typedef struct packed {
    logic                 done;
    logic                 err;
    logic [`AT_OUT_W-1:0] result;
  } uut_rsp_t;

  // signature sits in bytes 3..0, so byte 0 is its low byte
  typedef struct packed {
    logic [`AT_OUT_W-1:0] expected;
    logic [`AT_IN2_W-1:0] in2;
    logic [`AT_IN1_W-1:0] in1;
    logic [31:0]          signature;
  } at_fields_t;

  typedef union packed {
    logic [15:0][7:0] bytes;
    at_fields_t       fields;
  } at_record_u;

endpackage

//--- verilog/at_record_buf.sv
`timescale 1ns/1ps
`include "at_settings.svh"

module at_record_buf (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear_i,
  input  logic                 load_en_i,
  input  at_pkg::at_byte_cnt_t byte_pos_i,
  input  logic [7:0]           data_i,
  output at_pkg::at_record_u   record_o,
  output logic                 sig_ok_o
);

  logic [3:0] slot;

  // signature arrives msb first, the other fields lsb first
  always_comb begin
    if (byte_pos_i < 10'd4) begin
      slot = 4'd3 - byte_pos_i[3:0];
    end else begin
      slot = byte_pos_i[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      record_o <= '0;
    end else if (load_en_i && byte_pos_i < 10'd16) begin
      record_o.bytes[slot] <= data_i;
    end
  end

  assign sig_ok_o = (record_o.fields.signature == `AT_SIGNATURE);

endmodule

//--- verilog/at_result_check.sv
`timescale 1ns/1ps
`include "at_settings.svh"

module at_result_check (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear_i,
  input  logic                 capture_i,
  input  logic                 compare_en_i,
  input  at_pkg::at_record_u   record_i,
  input  logic [`AT_OUT_W-1:0] uut_result_i,
  input  logic                 uut_err_i,
  input  logic [31:0]          exec_cycles_i,
  input  at_pkg::at_byte_cnt_t byte_pos_i,
  output logic [31:0]          err_count_o,
  output logic [7:0]           wr_byte_o
);

  logic [`AT_OUT_W-1:0] result_q;
  logic                 err_q;
  logic [4:0]           bit_sel;

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      result_q <= '0;
      err_q    <= 1'b0;
    end else if (capture_i) begin
      result_q <= uut_result_i;
      err_q    <= uut_err_i;
    end
  end

  // an error flag counts even with a matching result
  always_ff @(posedge clk) begin
    if (rst) begin
      err_count_o <= '0;
    end else if (compare_en_i && (err_q || result_q != record_i.fields.expected)) begin
      err_count_o <= err_count_o + 32'd1;
    end
  end

  assign bit_sel = {byte_pos_i[1:0], 3'b000};

  always_comb begin
    if (byte_pos_i < 10'd4) begin
      wr_byte_o = record_i.bytes[4'd3 - byte_pos_i[3:0]];
    end else if (byte_pos_i < 10'd16) begin
      wr_byte_o = record_i.bytes[byte_pos_i[3:0]];
    end else if (byte_pos_i < 10'd20) begin
      wr_byte_o = result_q[bit_sel +: 8];
    end else if (byte_pos_i < 10'd24) begin
      wr_byte_o = exec_cycles_i[bit_sel +: 8];
    end else begin
      wr_byte_o = 8'hFF;
    end
  end

endmodule

//--- verilog/at_settings.svh
`ifndef AT_SETTINGS_SVH
`define AT_SETTINGS_SVH

// uut operand and result widths
`define AT_IN1_W 32
`define AT_IN2_W 32
`define AT_OUT_W 32

// sd block geometry
`define AT_BLOCK_BYTES 512

// first word of every valid test record
`define AT_SIGNATURE 32'hAABBCCDD

// block address of the first test record
`define AT_FIRST_BLOCK 32'h0010_0000

// uut run limit in clock cycles
`define AT_TIMEOUT_CYCLES 200

`endif

//--- verilog/sd_autotest.sv
`timescale 1ns/1ps

module sd_autotest (
  input  logic             clk,
  input  logic             rst,
  input  logic             start_i,
  input  at_pkg::sd_rsp_t  sd_rsp_i,
  output at_pkg::sd_req_t  sd_req_o,
  input  at_pkg::uut_rsp_t uut_rsp_i,
  output at_pkg::uut_req_t uut_req_o,
  output logic [31:0]      err_count_o,
  output logic             running_o
);

  import at_pkg::*;

  logic         sd_rst;
  logic         r_block;
  logic         r_byte;
  logic         w_block;
  logic         w_byte;
  logic         uut_rst;
  logic         byte_clr;
  logic         byte_inc;
  logic         blk_clr;
  logic         blk_inc;
  logic         tmr_clr;
  logic         tmr_run;
  logic         load_en;
  logic         capture;
  logic         compare_en;
  logic         clear_rec;
  logic         timeout;
  logic         sig_ok;
  at_byte_cnt_t byte_pos;
  logic [31:0]  block_addr;
  logic [31:0]  exec_cycles;
  at_record_u   record;
  logic [7:0]   wr_byte;

  at_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start_i),
    .sd_busy_i    (sd_rsp_i.busy),
    .uut_done_i   (uut_rsp_i.done),
    .uut_err_i    (uut_rsp_i.err),
    .byte_pos_i   (byte_pos),
    .timeout_i    (timeout),
    .sig_ok_i     (sig_ok),
    .sd_rst_o     (sd_rst),
    .r_block_o    (r_block),
    .r_byte_o     (r_byte),
    .w_block_o    (w_block),
    .w_byte_o     (w_byte),
    .uut_rst_o    (uut_rst),
    .running_o    (running_o),
    .byte_clr_o   (byte_clr),
    .byte_inc_o   (byte_inc),
    .blk_clr_o    (blk_clr),
    .blk_inc_o    (blk_inc),
    .tmr_clr_o    (tmr_clr),
    .tmr_run_o    (tmr_run),
    .load_en_o    (load_en),
    .capture_o    (capture),
    .compare_en_o (compare_en),
    .clear_rec_o  (clear_rec)
  );

  at_counters u_counters (
    .clk           (clk),
    .rst           (rst),
    .byte_clr_i    (byte_clr),
    .byte_inc_i    (byte_inc),
    .blk_clr_i     (blk_clr),
    .blk_inc_i     (blk_inc),
    .tmr_clr_i     (tmr_clr),
    .tmr_run_i     (tmr_run),
    .byte_pos_o    (byte_pos),
    .block_addr_o  (block_addr),
    .exec_cycles_o (exec_cycles),
    .timeout_o     (timeout)
  );

  at_record_buf u_record (
    .clk        (clk),
    .rst        (rst),
    .clear_i    (clear_rec),
    .load_en_i  (load_en),
    .byte_pos_i (byte_pos),
    .data_i     (sd_rsp_i.data_out),
    .record_o   (record),
    .sig_ok_o   (sig_ok)
  );

  at_result_check u_check (
    .clk           (clk),
    .rst           (rst),
    .clear_i       (clear_rec),
    .capture_i     (capture),
    .compare_en_i  (compare_en),
    .record_i      (record),
    .uut_result_i  (uut_rsp_i.result),
    .uut_err_i     (uut_rsp_i.err),
    .exec_cycles_i (exec_cycles),
    .byte_pos_i    (byte_pos),
    .err_count_o   (err_count_o),
    .wr_byte_o     (wr_byte)
  );

  assign sd_req_o = '{
    rst:        sd_rst,
    r_block:    r_block,
    r_byte:     r_byte,
    w_block:    w_block,
    w_byte:     w_byte,
    block_addr: block_addr,
    data_in:    wr_byte
  };

  assign uut_req_o = '{
    rst: uut_rst,
    in1: record.fields.in1,
    in2: record.fields.in2
  };

endmodule
